// ==== design/python_pixel_src.sv ====
//----------------------------------------------------------
// ramp pattern for the four data lanes, registered on the
// word enable together with its control code
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_pixel_src (
	input  wire                     clk_python,
	input  wire                     i_reset,
	input  wire                     i_word_en,
	input  wire                     i_lval,
	input  wire python_pkg::dim_t   i_col,
	input  wire python_pkg::dim_t   i_row,
	input  wire python_pkg::pix_t   i_code,
	output python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] o_pix,
	output python_pkg::pix_t        o_code
);

	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] ramp;

	// lane k: 4c + k + 16r, wraps at 1024
	always_comb begin
		for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
			ramp[k] = python_pkg::pix_t'({i_col, 2'b00}) + python_pkg::pix_t'(k)
				+ python_pkg::pix_t'({i_row, 4'b0000});
		end
	end

	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			o_pix  <= '0;
			o_code <= python_pkg::SYNC_TR;
		end else if (i_word_en) begin
			// sync and blanking words carry zero data
			o_pix  <= i_lval ? ramp : '0;
			o_code <= i_code;
		end
	end

endmodule

`default_nettype wire

// ==== design/python_pkg.sv ====
//----------------------------------------------------------
// shared widths, register map and sync codes for the
// PYTHON LVDS transmit model; modules refer to these by
// scoped names
//----------------------------------------------------------
`default_nettype none

package python_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int DATA_WIDTH  = 10;
	localparam int CHANNEL_NUM = 4;

	// one serial word
	typedef logic [DATA_WIDTH-1:0] pix_t;
	// width, height, blanking in words or lines
	typedef logic [11:0] dim_t;
	// frame counter
	typedef logic [15:0] cnt_t;

	// ------------------------------------------------------------
	// control lane sync codes
	// ------------------------------------------------------------
	localparam pix_t SYNC_TR  = 10'h3A6;
	localparam pix_t SYNC_FS  = 10'h2AA;
	localparam pix_t SYNC_LS  = 10'h0AA;
	localparam pix_t SYNC_LE  = 10'h12A;
	localparam pix_t SYNC_FE  = 10'h32A;
	localparam pix_t SYNC_IMG = 10'h035;

	// ------------------------------------------------------------
	// AXI4-Lite register map, byte addresses
	// ------------------------------------------------------------
	localparam logic [7:0] REG_CTRL   = 8'h00;
	localparam logic [7:0] REG_WIDTH  = 8'h04;
	localparam logic [7:0] REG_HEIGHT = 8'h08;
	localparam logic [7:0] REG_LHIDE  = 8'h0C;
	localparam logic [7:0] REG_FHIDE  = 8'h10;
	localparam logic [7:0] REG_STATUS = 8'h14;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// register defaults after reset
	localparam dim_t RST_WIDTH  = 12'd4;
	localparam dim_t RST_HEIGHT = 12'd3;
	localparam dim_t RST_LHIDE  = 12'd2;
	localparam dim_t RST_FHIDE  = 12'd3;

	// frame/line FSM
	typedef enum logic [1:0] {
		IDLE,
		FRAME_HIDE,
		LINE_ACTIVE,
		LINE_HIDE
	} timing_state_e;

endpackage

`default_nettype wire

// ==== design/python_regs.sv ====
//----------------------------------------------------------
// AXI4-Lite slave holding the sensor configuration
// AW and W are taken together, one transfer in flight per
// direction; STATUS returns the frame count
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_regs (
	input  wire                     clk_python,
	input  wire                     i_reset,
	// write address and data
	input  wire                     i_awvalid,
	output logic                    o_awready,
	input  wire  [7:0]              i_awaddr,
	input  wire                     i_wvalid,
	output logic                    o_wready,
	input  wire  [31:0]             i_wdata,
	input  wire  [3:0]              i_wstrb,
	output logic                    o_bvalid,
	input  wire                     i_bready,
	output logic [1:0]              o_bresp,
	// read
	input  wire                     i_arvalid,
	output logic                    o_arready,
	input  wire  [7:0]              i_araddr,
	output logic                    o_rvalid,
	input  wire                     i_rready,
	output logic [31:0]             o_rdata,
	output logic [1:0]              o_rresp,
	// to and from the timing
	input  wire                     i_frame_done,
	output logic                    o_enable,
	output python_pkg::dim_t        o_width,
	output python_pkg::dim_t        o_height,
	output python_pkg::dim_t        o_lhide,
	output python_pkg::dim_t        o_fhide
);

	logic               wr_fire;
	logic               rd_fire;
	logic               wr_ok;
	python_pkg::cnt_t   frame_cnt;
	logic [31:0]        rd_data;
	logic               rd_ok;

	// byte lanes 0 and 1 cover the 12-bit fields
	function automatic python_pkg::dim_t wr_dim(python_pkg::dim_t cur, logic [31:0] data,
			logic [3:0] strb);
		python_pkg::dim_t res;
		res = cur;
		if (strb[0]) res[7:0] = data[7:0];
		if (strb[1]) res[11:8] = data[11:8];
		return res;
	endfunction

	// both write channels must be valid, one response outstanding
	assign wr_fire   = i_awvalid && i_wvalid && !o_bvalid;
	assign o_awready = wr_fire;
	assign o_wready  = wr_fire;
	assign rd_fire   = i_arvalid && !o_rvalid;
	assign o_arready = !o_rvalid;

	// writable addresses only, STATUS is read only
	assign wr_ok = (i_awaddr == python_pkg::REG_CTRL) || (i_awaddr == python_pkg::REG_WIDTH)
		|| (i_awaddr == python_pkg::REG_HEIGHT) || (i_awaddr == python_pkg::REG_LHIDE)
		|| (i_awaddr == python_pkg::REG_FHIDE);

	// ------------------------------------------------------------
	// read mux
	// ------------------------------------------------------------
	always_comb begin
		rd_data = '0;
		rd_ok   = 1'b1;
		case (i_araddr)
			python_pkg::REG_CTRL:   rd_data[0]     = o_enable;
			python_pkg::REG_WIDTH:  rd_data[11:0]  = o_width;
			python_pkg::REG_HEIGHT: rd_data[11:0]  = o_height;
			python_pkg::REG_LHIDE:  rd_data[11:0]  = o_lhide;
			python_pkg::REG_FHIDE:  rd_data[11:0]  = o_fhide;
			python_pkg::REG_STATUS: rd_data[15:0]  = frame_cnt;
			default:                rd_ok          = 1'b0;
		endcase
	end

	// ------------------------------------------------------------
	// config registers and handshake state
	// ------------------------------------------------------------
	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			o_bvalid  <= 1'b0;
			o_rvalid  <= 1'b0;
			o_enable  <= 1'b0;
			o_width   <= python_pkg::RST_WIDTH;
			o_height  <= python_pkg::RST_HEIGHT;
			o_lhide   <= python_pkg::RST_LHIDE;
			o_fhide   <= python_pkg::RST_FHIDE;
			frame_cnt <= '0;
		end else begin
			if (wr_fire) begin
				o_bvalid <= 1'b1;
			end else if (i_bready) begin
				o_bvalid <= 1'b0;
			end
			if (rd_fire) begin
				o_rvalid <= 1'b1;
			end else if (i_rready) begin
				o_rvalid <= 1'b0;
			end
			if (wr_fire) begin
				case (i_awaddr)
					python_pkg::REG_CTRL:   if (i_wstrb[0]) o_enable <= i_wdata[0];
					python_pkg::REG_WIDTH:  o_width  <= wr_dim(o_width, i_wdata, i_wstrb);
					python_pkg::REG_HEIGHT: o_height <= wr_dim(o_height, i_wdata, i_wstrb);
					python_pkg::REG_LHIDE:  o_lhide  <= wr_dim(o_lhide, i_wdata, i_wstrb);
					python_pkg::REG_FHIDE:  o_fhide  <= wr_dim(o_fhide, i_wdata, i_wstrb);
					default: ;
				endcase
			end
			if (i_frame_done) frame_cnt <= frame_cnt + 16'd1;
		end
	end

	// response payload
	always_ff @(posedge clk_python) begin
		if (wr_fire) o_bresp <= wr_ok ? python_pkg::RESP_OKAY : python_pkg::RESP_SLVERR;
		if (rd_fire) begin
			o_rdata <= rd_data;
			o_rresp <= rd_ok ? python_pkg::RESP_OKAY : python_pkg::RESP_SLVERR;
		end
	end

	// write response held until the master takes it
	a_bvalid_hold: assert property (@(posedge clk_python) disable iff (i_reset)
		o_bvalid && !i_bready |=> o_bvalid);

endmodule

`default_nettype wire

// ==== design/python_serializer.sv ====
//----------------------------------------------------------
// word enable divider and MSB-first shifters for four data
// lanes and the control lane, one bit per clock
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_serializer (
	input  wire                     clk_python,
	input  wire                     i_reset,
	input  wire python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] i_pix,
	input  wire python_pkg::pix_t   i_code,
	output logic                    o_word_en,
	output logic [python_pkg::CHANNEL_NUM-1:0] o_ser_data,
	output logic                    o_ser_ctrl
);

	localparam logic [3:0] DIV_LAST = 4'(python_pkg::DATA_WIDTH - 1);

	logic [3:0] div_cnt;
	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] sh_data;
	python_pkg::pix_t sh_ctrl;

	// ------------------------------------------------------------
	// divide by DATA_WIDTH
	// ------------------------------------------------------------
	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			div_cnt <= '0;
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 4'd1;
		end
	end

	// one word slot per DATA_WIDTH clocks
	assign o_word_en = (div_cnt == DIV_LAST);

	// ------------------------------------------------------------
	// shift registers
	// ------------------------------------------------------------
	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			// control lane idles on training, data lanes at zero
			sh_ctrl <= python_pkg::SYNC_TR;
			sh_data <= '0;
		end else if (o_word_en) begin
			sh_ctrl <= i_code;
			sh_data <= i_pix;
		end else begin
			sh_ctrl <= {sh_ctrl[python_pkg::DATA_WIDTH-2:0], 1'b0};
			for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
				sh_data[k] <= {sh_data[k][python_pkg::DATA_WIDTH-2:0], 1'b0};
			end
		end
	end

	// MSB leads
	always_comb begin
		for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
			o_ser_data[k] = sh_data[k][python_pkg::DATA_WIDTH-1];
		end
	end
	assign o_ser_ctrl = sh_ctrl[python_pkg::DATA_WIDTH-1];

	// divider stays in range
	a_div_range: assert property (@(posedge clk_python) disable iff (i_reset)
		div_cnt <= DIV_LAST);

endmodule

`default_nettype wire

// ==== design/python_timing.sv ====
//----------------------------------------------------------
// frame and line timing, one step per word enable
// yields fval/lval, pixel position and the control code;
// dimensions are sampled at each frame start
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_timing (
	input  wire                     clk_python,
	input  wire                     i_reset,
	input  wire                     i_word_en,
	input  wire                     i_enable,
	input  wire python_pkg::dim_t   i_width,
	input  wire python_pkg::dim_t   i_height,
	input  wire python_pkg::dim_t   i_lhide,
	input  wire python_pkg::dim_t   i_fhide,
	output logic                    o_fval,
	output logic                    o_lval,
	output python_pkg::dim_t        o_col,
	output python_pkg::dim_t        o_row,
	output python_pkg::pix_t        o_code,
	output logic                    o_frame_done
);

	python_pkg::timing_state_e state;
	// word position inside the current state
	python_pkg::dim_t cnt;
	python_pkg::dim_t row;
	python_pkg::dim_t width_q;
	python_pkg::dim_t height_q;
	python_pkg::dim_t lhide_q;
	python_pkg::dim_t fhide_q;
	logic last_row;
	logic line_end;
	logic start_frame;

	assign last_row = (row == height_q - 12'd1);
	// last word of a line, its final blanking word or LE when there is no blanking
	assign line_end = (state == python_pkg::LINE_HIDE && cnt == lhide_q - 12'd1)
		|| (state == python_pkg::LINE_ACTIVE && cnt == width_q + 12'd1 && lhide_q == '0);
	// enable is only looked at between frames
	assign start_frame = i_enable && (state == python_pkg::IDLE || (line_end && last_row));

	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			state        <= python_pkg::IDLE;
			cnt          <= '0;
			row          <= '0;
			o_fval       <= 1'b0;
			o_lval       <= 1'b0;
			o_col        <= '0;
			o_row        <= '0;
			o_code       <= python_pkg::SYNC_TR;
			o_frame_done <= 1'b0;
		end else begin
			o_frame_done <= 1'b0;
			if (i_word_en) begin
				// blanking word unless overridden
				o_lval <= 1'b0;
				o_code <= python_pkg::SYNC_TR;
				cnt    <= cnt + 12'd1;
				case (state)
					python_pkg::IDLE: begin
						o_fval <= 1'b0;
						cnt    <= '0;
					end
					python_pkg::FRAME_HIDE: begin
						o_fval <= 1'b0;
						if (cnt == fhide_q - 12'd1) begin
							state <= python_pkg::LINE_ACTIVE;
							cnt   <= '0;
						end
					end
					python_pkg::LINE_ACTIVE: begin
						o_fval <= 1'b1;
						if (cnt == '0) begin
							// FS replaces LS on the first line
							o_code <= (row == '0) ? python_pkg::SYNC_FS : python_pkg::SYNC_LS;
						end else if (cnt <= width_q) begin
							o_lval <= 1'b1;
							o_code <= python_pkg::SYNC_IMG;
							o_col  <= cnt - 12'd1;
							o_row  <= row;
						end else begin
							o_code       <= last_row ? python_pkg::SYNC_FE : python_pkg::SYNC_LE;
							o_frame_done <= last_row;
							state        <= python_pkg::LINE_HIDE;
							cnt          <= '0;
						end
					end
					python_pkg::LINE_HIDE: o_fval <= !last_row;
					default: state <= python_pkg::IDLE;
				endcase
				if (line_end) begin
					cnt <= '0;
					if (last_row) begin
						state <= python_pkg::IDLE;
					end else begin
						row   <= row + 12'd1;
						state <= python_pkg::LINE_ACTIVE;
					end
				end
				// new frame, takes the current register values
				if (start_frame) begin
					width_q  <= i_width;
					height_q <= i_height;
					lhide_q  <= i_lhide;
					fhide_q  <= i_fhide;
					row      <= '0;
					cnt      <= '0;
					state    <= (i_fhide != '0) ? python_pkg::FRAME_HIDE
						: python_pkg::LINE_ACTIVE;
				end
			end
		end
	end

	// image words only come out of an open line inside a frame
	a_lval_in_fval: assert property (@(posedge clk_python) disable iff (i_reset)
		o_lval |-> o_fval && state == python_pkg::LINE_ACTIVE);

endmodule

`default_nettype wire

// ==== design/python_tx_top.sv ====
//----------------------------------------------------------
// PYTHON LVDS transmit model, AXI4-Lite configured
// serial lanes lag the timing by two word slots
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_tx_top (
	input  wire                     clk_python,
	input  wire                     i_reset,
	input  wire                     i_awvalid,
	output logic                    o_awready,
	input  wire  [7:0]              i_awaddr,
	input  wire                     i_wvalid,
	output logic                    o_wready,
	input  wire  [31:0]             i_wdata,
	input  wire  [3:0]              i_wstrb,
	output logic                    o_bvalid,
	input  wire                     i_bready,
	output logic [1:0]              o_bresp,
	input  wire                     i_arvalid,
	output logic                    o_arready,
	input  wire  [7:0]              i_araddr,
	output logic                    o_rvalid,
	input  wire                     i_rready,
	output logic [31:0]             o_rdata,
	output logic [1:0]              o_rresp,
	output logic [python_pkg::CHANNEL_NUM-1:0] o_ser_data,
	output logic                    o_ser_ctrl,
	output logic                    o_fval_mon
);

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	logic             enable;
	python_pkg::dim_t width;
	python_pkg::dim_t height;
	python_pkg::dim_t lhide;
	python_pkg::dim_t fhide;
	logic             frame_done;
	logic             word_en;
	logic             fval;
	logic             lval;
	python_pkg::dim_t col;
	python_pkg::dim_t row;
	python_pkg::pix_t tim_code;
	python_pkg::pix_t pix_code;
	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] pix;

	python_regs u_regs (
		.clk_python   (clk_python),
		.i_reset      (i_reset),
		.i_awvalid    (i_awvalid),
		.o_awready    (o_awready),
		.i_awaddr     (i_awaddr),
		.i_wvalid     (i_wvalid),
		.o_wready     (o_wready),
		.i_wdata      (i_wdata),
		.i_wstrb      (i_wstrb),
		.o_bvalid     (o_bvalid),
		.i_bready     (i_bready),
		.o_bresp      (o_bresp),
		.i_arvalid    (i_arvalid),
		.o_arready    (o_arready),
		.i_araddr     (i_araddr),
		.o_rvalid     (o_rvalid),
		.i_rready     (i_rready),
		.o_rdata      (o_rdata),
		.o_rresp      (o_rresp),
		.i_frame_done (frame_done),
		.o_enable     (enable),
		.o_width      (width),
		.o_height     (height),
		.o_lhide      (lhide),
		.o_fhide      (fhide)
	);

	// word n chosen here
	python_timing u_timing (
		.clk_python   (clk_python),
		.i_reset      (i_reset),
		.i_word_en    (word_en),
		.i_enable     (enable),
		.i_width      (width),
		.i_height     (height),
		.i_lhide      (lhide),
		.i_fhide      (fhide),
		.o_fval       (fval),
		.o_lval       (lval),
		.o_col        (col),
		.o_row        (row),
		.o_code       (tim_code),
		.o_frame_done (frame_done)
	);

	// word n+1, pixels and code registered together
	python_pixel_src u_pixel_src (
		.clk_python (clk_python),
		.i_reset    (i_reset),
		.i_word_en  (word_en),
		.i_lval     (lval),
		.i_col      (col),
		.i_row      (row),
		.i_code     (tim_code),
		.o_pix      (pix),
		.o_code     (pix_code)
	);

	// word n+2, onto the lanes
	python_serializer u_serializer (
		.clk_python (clk_python),
		.i_reset    (i_reset),
		.i_pix      (pix),
		.i_code     (pix_code),
		.o_word_en  (word_en),
		.o_ser_data (o_ser_data),
		.o_ser_ctrl (o_ser_ctrl)
	);

	assign o_fval_mon = fval;

endmodule

`default_nettype wire

// ==== sources.f ====
design/python_pkg.sv
design/python_regs.sv
design/python_timing.sv
design/python_pixel_src.sv
design/python_serializer.sv
design/python_tx_top.sv
verif/python_rx_checker.sv
verif/tb_python_tx.sv

// ==== verif/python_rx_checker.sv ====
//----------------------------------------------------------
// serial receiver for the PYTHON transmit model; aligns on
// the training word, rebuilds words and checks the frame
// format and the ramp pattern with concurrent assertions
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module python_rx_checker (
	input  wire                     clk_python,
	input  wire                     i_reset,
	input  wire [python_pkg::CHANNEL_NUM-1:0] i_ser_data,
	input  wire                     i_ser_ctrl,
	input  wire python_pkg::dim_t   i_width,
	input  wire python_pkg::dim_t   i_height,
	input  wire python_pkg::dim_t   i_lhide,
	input  wire python_pkg::dim_t   i_fhide,
	input  wire                     i_expect_idle,
	output logic                    o_locked,
	output logic                    o_in_frame,
	output int                      o_word_cnt,
	output int                      o_tr_run,
	output python_pkg::cnt_t        o_fe_count
);

	localparam int W = python_pkg::DATA_WIDTH;

	python_pkg::pix_t ctrl_sr;
	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] data_sr;
	logic [3:0] bit_cnt;
	// one rebuilt word per pulse
	logic w_v;
	python_pkg::pix_t w_ctrl;
	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] w_data;
	// position inside the frame
	logic in_line;
	logic seen_fe;
	int col;
	int row;
	int blank_cnt;
	python_pkg::pix_t exp_code;
	python_pkg::pix_t [python_pkg::CHANNEL_NUM-1:0] exp_data;
	logic data_ok;
	python_pkg::pix_t bad_exp;
	python_pkg::pix_t bad_act;

	// ------------------------------------------------------------
	// deserializer, MSB arrives first
	// ------------------------------------------------------------
	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			ctrl_sr  <= '0;
			data_sr  <= '0;
			bit_cnt  <= '0;
			o_locked <= 1'b0;
			w_v      <= 1'b0;
		end else begin
			ctrl_sr <= {ctrl_sr[W-2:0], i_ser_ctrl};
			for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
				data_sr[k] <= {data_sr[k][W-2:0], i_ser_data[k]};
			end
			w_v <= 1'b0;
			if (!o_locked) begin
				// training word is unique under rotation
				if ({ctrl_sr[W-2:0], i_ser_ctrl} == python_pkg::SYNC_TR) begin
					o_locked <= 1'b1;
					bit_cnt  <= '0;
				end
			end else if (bit_cnt == 4'(W - 1)) begin
				bit_cnt <= '0;
				w_v     <= 1'b1;
				w_ctrl  <= {ctrl_sr[W-2:0], i_ser_ctrl};
				for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
					w_data[k] <= {data_sr[k][W-2:0], i_ser_data[k]};
				end
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// ------------------------------------------------------------
	// frame tracking
	// ------------------------------------------------------------
	always_ff @(posedge clk_python) begin
		if (i_reset) begin
			o_in_frame <= 1'b0;
			in_line    <= 1'b0;
			seen_fe    <= 1'b0;
			col        <= 0;
			row        <= 0;
			blank_cnt  <= 0;
			o_word_cnt <= 0;
			o_tr_run   <= 0;
			o_fe_count <= '0;
		end else if (w_v) begin
			o_word_cnt <= o_word_cnt + 1;
			o_tr_run   <= (w_ctrl == python_pkg::SYNC_TR) ? o_tr_run + 1 : 0;
			blank_cnt  <= blank_cnt + 1;
			case (w_ctrl)
				python_pkg::SYNC_FS: begin
					o_in_frame <= 1'b1;
					in_line    <= 1'b1;
					row        <= 0;
					col        <= 0;
				end
				python_pkg::SYNC_LS: begin
					in_line <= 1'b1;
					col     <= 0;
				end
				python_pkg::SYNC_IMG: col <= col + 1;
				python_pkg::SYNC_LE: begin
					in_line   <= 1'b0;
					row       <= row + 1;
					blank_cnt <= 0;
				end
				python_pkg::SYNC_FE: begin
					in_line    <= 1'b0;
					o_in_frame <= 1'b0;
					seen_fe    <= 1'b1;
					blank_cnt  <= 0;
					o_fe_count <= o_fe_count + 16'd1;
				end
				default: ;
			endcase
		end
	end

	// next control word from the frame format
	always_comb begin
		if (!o_in_frame) begin
			// FS only after the full frame gap, never once idle is expected
			if (w_ctrl == python_pkg::SYNC_FS && !i_expect_idle
					&& (!seen_fe || blank_cnt == int'(i_lhide) + int'(i_fhide))) begin
				exp_code = python_pkg::SYNC_FS;
			end else begin
				exp_code = python_pkg::SYNC_TR;
			end
		end else if (!in_line) begin
			exp_code = (blank_cnt < int'(i_lhide)) ? python_pkg::SYNC_TR : python_pkg::SYNC_LS;
		end else if (col < int'(i_width)) begin
			exp_code = python_pkg::SYNC_IMG;
		end else begin
			exp_code = (row == int'(i_height) - 1) ? python_pkg::SYNC_FE : python_pkg::SYNC_LE;
		end
	end

	// lane k carries 4c + k + 16r mod 1024 on image words, zero otherwise
	always_comb begin
		data_ok = 1'b1;
		bad_exp = '0;
		bad_act = '0;
		for (int k = 0; k < python_pkg::CHANNEL_NUM; k++) begin
			exp_data[k] = '0;
			if (w_ctrl == python_pkg::SYNC_IMG) begin
				exp_data[k] = python_pkg::pix_t'((4 * col + k + 16 * row) % (1 << W));
			end
			if (w_data[k] != exp_data[k]) begin
				data_ok = 1'b0;
				bad_exp = exp_data[k];
				bad_act = w_data[k];
			end
		end
	end

	a_ctrl_word: assert property (@(posedge clk_python) disable iff (i_reset)
		w_v |-> w_ctrl == exp_code)
		else tb_python_tx.report_error("control word", $sampled(exp_code), $sampled(w_ctrl));

	a_lane_data: assert property (@(posedge clk_python) disable iff (i_reset)
		w_v |-> data_ok)
		else tb_python_tx.report_error("lane data", $sampled(bad_exp), $sampled(bad_act));

endmodule

`default_nettype wire

// ==== verif/tb_python_tx.sv ====
//----------------------------------------------------------
// testbench for the PYTHON transmit model; configures it
// over AXI4-Lite with random frame sizes and leaves the
// stream checks to the serial receiver
//----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_python_tx;

	logic clk_python;
	logic i_reset;
	logic i_awvalid;
	logic [7:0] i_awaddr;
	logic i_wvalid;
	logic [31:0] i_wdata;
	logic [3:0] i_wstrb;
	logic i_bready;
	logic i_arvalid;
	logic [7:0] i_araddr;
	logic i_rready;
	wire o_awready;
	wire o_wready;
	wire o_bvalid;
	wire [1:0] o_bresp;
	wire o_arready;
	wire o_rvalid;
	wire [31:0] o_rdata;
	wire [1:0] o_rresp;
	wire [python_pkg::CHANNEL_NUM-1:0] o_ser_data;
	wire o_ser_ctrl;
	wire o_fval_mon;

	// frame sizes the receiver expects
	python_pkg::dim_t exp_width;
	python_pkg::dim_t exp_height;
	python_pkg::dim_t exp_lhide;
	python_pkg::dim_t exp_fhide;
	logic expect_idle;
	logic locked;
	logic in_frame;
	int word_cnt;
	int tr_run;
	python_pkg::cnt_t fe_count;
	integer seed;
	logic [7:0] reg_addr [4];
	logic [31:0] reg_val [4];

	python_tx_top dut (
		.clk_python (clk_python),
		.i_reset    (i_reset),
		.i_awvalid  (i_awvalid),
		.o_awready  (o_awready),
		.i_awaddr   (i_awaddr),
		.i_wvalid   (i_wvalid),
		.o_wready   (o_wready),
		.i_wdata    (i_wdata),
		.i_wstrb    (i_wstrb),
		.o_bvalid   (o_bvalid),
		.i_bready   (i_bready),
		.o_bresp    (o_bresp),
		.i_arvalid  (i_arvalid),
		.o_arready  (o_arready),
		.i_araddr   (i_araddr),
		.o_rvalid   (o_rvalid),
		.i_rready   (i_rready),
		.o_rdata    (o_rdata),
		.o_rresp    (o_rresp),
		.o_ser_data (o_ser_data),
		.o_ser_ctrl (o_ser_ctrl),
		.o_fval_mon (o_fval_mon)
	);

	python_rx_checker rx_checker (
		.clk_python    (clk_python),
		.i_reset       (i_reset),
		.i_ser_data    (o_ser_data),
		.i_ser_ctrl    (o_ser_ctrl),
		.i_width       (exp_width),
		.i_height      (exp_height),
		.i_lhide       (exp_lhide),
		.i_fhide       (exp_fhide),
		.i_expect_idle (expect_idle),
		.o_locked      (locked),
		.o_in_frame    (in_frame),
		.o_word_cnt    (word_cnt),
		.o_tr_run      (tr_run),
		.o_fe_count    (fe_count)
	);

	initial begin
		clk_python = 1'b0;
		forever #5 clk_python = ~clk_python;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		abort_run($sformatf("[ERROR] %s: expected 0x%0h, actual 0x%0h", name, exp, act));
	endtask

	task automatic expect_equal(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act == exp) else report_error(name, exp, act);
	endtask

	// AW and W together until both ready, then wait out the response
	task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		logic accepted;
		@(negedge clk_python);
		i_awvalid = 1'b1;
		i_awaddr  = addr;
		i_wvalid  = 1'b1;
		i_wdata   = data;
		i_wstrb   = 4'hf;
		accepted  = 1'b0;
		n = 0;
		while (!accepted) begin
			@(posedge clk_python);
			accepted = o_awready && o_wready;
			n++;
			if (!accepted && n > 50) abort_run("AXI write address and data not accepted");
		end
		@(negedge clk_python);
		i_awvalid = 1'b0;
		i_wvalid  = 1'b0;
		n = 0;
		while (!o_bvalid) begin
			@(negedge clk_python);
			n++;
			if (n > 50) abort_run("AXI write got no response");
		end
		resp     = o_bresp;
		i_bready = 1'b1;
		@(negedge clk_python);
		i_bready = 1'b0;
	endtask

	task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		logic accepted;
		@(negedge clk_python);
		i_arvalid = 1'b1;
		i_araddr  = addr;
		accepted  = 1'b0;
		n = 0;
		while (!accepted) begin
			@(posedge clk_python);
			accepted = o_arready;
			n++;
			if (!accepted && n > 50) abort_run("AXI read address not accepted");
		end
		@(negedge clk_python);
		i_arvalid = 1'b0;
		n = 0;
		while (!o_rvalid) begin
			@(negedge clk_python);
			n++;
			if (n > 50) abort_run("AXI read got no response");
		end
		data     = o_rdata;
		resp     = o_rresp;
		i_rready = 1'b1;
		@(negedge clk_python);
		i_rready = 1'b0;
	endtask

	task automatic wait_words(input int count);
		int start;
		int n;
		start = word_cnt;
		n = 0;
		while (word_cnt < start + count) begin
			@(negedge clk_python);
			n++;
			if (n > count * python_pkg::DATA_WIDTH + 100) abort_run("serial words stopped");
		end
	endtask

	// ------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------
	initial begin
		int n;
		int fe_before;
		logic [31:0] rdata;
		logic [1:0] resp;
		logic fval_seen;
		seed        = 32'hc003_86f6;
		i_reset     = 1'b1;
		i_awvalid   = 1'b0;
		i_awaddr    = '0;
		i_wvalid    = 1'b0;
		i_wdata     = '0;
		i_wstrb     = '0;
		i_bready    = 1'b0;
		i_arvalid   = 1'b0;
		i_araddr    = '0;
		i_rready    = 1'b0;
		expect_idle = 1'b1;
		fval_seen   = 1'b0;
		// sizes for the run, height of two or more lines
		exp_width  = python_pkg::dim_t'(1 + $unsigned($random(seed)) % 8);
		exp_height = python_pkg::dim_t'(2 + $unsigned($random(seed)) % 4);
		exp_lhide  = python_pkg::dim_t'($unsigned($random(seed)) % 4);
		exp_fhide  = python_pkg::dim_t'($unsigned($random(seed)) % 4);
		reg_addr   = '{python_pkg::REG_WIDTH, python_pkg::REG_HEIGHT,
			python_pkg::REG_LHIDE, python_pkg::REG_FHIDE};
		reg_val    = '{32'(exp_width), 32'(exp_height), 32'(exp_lhide), 32'(exp_fhide)};
		repeat (10) @(negedge clk_python);
		i_reset = 1'b0;

		n = 0;
		while (!locked) begin
			@(negedge clk_python);
			n++;
			if (n > 200) abort_run("receiver never locked on training");
		end
		// idle stream checked by the receiver
		wait_words(8);
		read_reg(python_pkg::REG_CTRL, rdata, resp);
		expect_equal("ctrl after reset", 32'd0, rdata);
		expect_equal("fval while idle", 32'd0, 32'(o_fval_mon));

		for (int i = 0; i < 4; i++) begin
			write_reg(reg_addr[i], reg_val[i], resp);
			expect_equal("write response", 32'(python_pkg::RESP_OKAY), 32'(resp));
			read_reg(reg_addr[i], rdata, resp);
			expect_equal("register read back", reg_val[i], rdata);
		end
		write_reg(8'h20, 32'h1, resp);
		expect_equal("unmapped write", 32'(python_pkg::RESP_SLVERR), 32'(resp));
		read_reg(8'h20, rdata, resp);
		expect_equal("unmapped read", 32'(python_pkg::RESP_SLVERR), 32'(resp));
		write_reg(python_pkg::REG_STATUS, 32'h5, resp);
		expect_equal("status write", 32'(python_pkg::RESP_SLVERR), 32'(resp));

		// ------------------------------------------------------------
		// frames
		// ------------------------------------------------------------
		expect_idle = 1'b0;
		write_reg(python_pkg::REG_CTRL, 32'h1, resp);
		read_reg(python_pkg::REG_CTRL, rdata, resp);
		expect_equal("ctrl enabled", 32'd1, rdata);
		n = 0;
		while (fe_count < 16'd3 || !in_frame) begin
			@(negedge clk_python);
			if (o_fval_mon) fval_seen = 1'b1;
			n++;
			if (n > 20000) abort_run("frames did not arrive");
		end
		expect_equal("fval during frames", 32'd1, 32'(fval_seen));
		// stop in mid frame, that frame must still end
		fe_before = int'(fe_count);
		write_reg(python_pkg::REG_CTRL, 32'h0, resp);
		n = 0;
		while (tr_run <= int'(exp_lhide) + int'(exp_fhide) + 1) begin
			@(negedge clk_python);
			n++;
			if (n > 5000) abort_run("stream did not return to training");
		end
		expect_idle = 1'b1;
		expect_equal("frames after disable", 32'(fe_before + 1), 32'(fe_count));
		expect_equal("fval after disable", 32'd0, 32'(o_fval_mon));
		wait_words(20);
		read_reg(python_pkg::REG_STATUS, rdata, resp);
		expect_equal("frame count", 32'(fe_count), rdata);

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
